//--- common/mdc_data_pkg.sv
/*
  Data widths of the determinant calculator. Entries are signed 11-bit,
  results are sized so that no product or sum can overflow.
*/
package mdc_data_pkg;

    localparam int entry_w = 11;
    localparam int n_det2 = 9;
    localparam int n_det3 = 4;

    typedef logic signed [entry_w-1:0] entry_t;

    // Two products of entries plus one bit for the difference
    typedef logic signed [2*entry_w:0] det2_t;

    typedef logic signed [50:0] det3_t;

    // Row 0 sits in the most significant bits, row-major
    typedef struct packed {
        entry_t [0:3][0:3] e;
    } matrix_t;

    localparam int result_w = 207;

    typedef logic [result_w-1:0] result_t;

endpackage

//--- common/mdc_ctrl_pkg.sv
/*
  Control side definitions. Only mode_det3 selects the 3x3 result,
  any other decoded mode word falls back to the 2x2 windows.
*/
package mdc_ctrl_pkg;

    localparam int mode_w = 5;
    localparam int mode_code_w = 9;
    localparam int data_code_w = 15;

    typedef logic [mode_w-1:0] mode_t;

    localparam mode_t mode_det3 = 5'b00110;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        CALC,
        OUT
    } phase_t;

    typedef logic [3:0] step_t;

    localparam int det2_steps = 9;
    localparam int det3_steps = 12;

    typedef struct packed {
        logic  det2_en;
        logic  det3_en;
        step_t step;
        logic  load;
        logic  sel_det3;
    } ctrl_t;

endpackage

//--- src/hamming_decoder.sv
/*
  Single-error-correcting Hamming decoder, purely combinational.
  Position 1 is the MSB; powers of two carry parity. Double errors
  are not detected and give a wrong payload.
*/
`timescale 1ns/10ps

module hamming_decoder #(
    parameter type payload_t = logic [10:0],
    localparam int data_w = $bits(payload_t),
    localparam int par_w = $clog2(data_w + $clog2(data_w) + 1),
    localparam int code_w = data_w + par_w
) (
    input  logic [code_w-1:0] code,
    output payload_t          data
);

    logic [par_w-1:0]  syndrome;
    logic [code_w-1:0] fixed;
    logic [data_w-1:0] bits;

    // XOR of the positions of all set bits
    always_comb begin
        syndrome = '0;
        for (int pos = 1; pos <= code_w; pos++) begin
            if (code[code_w-pos]) begin
                syndrome = syndrome ^ par_w'(pos);
            end
        end
    end

    always_comb begin
        fixed = code;
        if (syndrome != '0 && syndrome <= code_w) begin
            fixed[code_w-syndrome] = ~code[code_w-syndrome];
        end
    end

    // Data bits in MSB-first order, skipping parity positions
    always_comb begin
        int k;
        k = data_w - 1;
        bits = '0;
        for (int pos = 1; pos <= code_w; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                bits[k] = fixed[code_w-pos];
                k = k - 1;
            end
        end
    end

    assign data = payload_t'(bits);

endmodule

//--- src/mdc_ctrl.sv
/*
  Phase FSM for one matrix at a time. The mode word is taken with the
  first entry only; a new matrix must not start before out_valid.
*/
`timescale 1ns/10ps

module mdc_ctrl import mdc_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [mode_code_w-1:0] in_mode,
    output ctrl_t                  ctrl
);

    phase_t                 phase;
    phase_t                 phase_nx;
    logic [mode_code_w-1:0] mode_code;
    mode_t                  mode;
    logic                   valid_q;
    logic                   sel_det3;
    step_t                  step;
    logic                   calc_last;

    hamming_decoder #(.payload_t(mode_t)) u_mode_dec (
        .code (mode_code),
        .data (mode)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            mode_code <= '0;
        end else begin
            valid_q <= in_valid;
            if (phase == IDLE && in_valid) begin
                mode_code <= in_mode;
            end
        end
    end

    assign calc_last = (step == (sel_det3 ? step_t'(det3_steps - 1) : step_t'(det2_steps - 1)));

    // ####################
    // Phase FSM
    // ####################
    always_comb begin
        phase_nx = phase;
        case (phase)
            IDLE: if (in_valid) phase_nx = READ;
            // Wait for the delayed valid so the last entry is stored
            READ: if (!valid_q) phase_nx = CALC;
            CALC: if (calc_last) phase_nx = OUT;
            OUT:  phase_nx = IDLE;
            default: phase_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= IDLE;
            step     <= '0;
            sel_det3 <= 1'b0;
        end else begin
            phase <= phase_nx;
            if (phase == CALC && !calc_last) begin
                step <= step + step_t'(1);
            end else begin
                step <= '0;
            end
            if (phase == READ && !valid_q) begin
                sel_det3 <= (mode == mode_det3);
            end
        end
    end

    always_comb begin
        ctrl.det2_en  = (phase == CALC) && !sel_det3;
        ctrl.det3_en  = (phase == CALC) && sel_det3;
        ctrl.step     = step;
        ctrl.load     = (phase == OUT);
        ctrl.sel_det3 = sel_det3;
    end

endmodule

//--- src/matrix_store.sv
/*
  Holds the sixteen decoded entries, written in row-major order.
  The pointer restarts whenever valid drops, so every burst must be
  exactly sixteen entries long.
*/
`timescale 1ns/10ps

module matrix_store import mdc_data_pkg::*, mdc_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [data_code_w-1:0] in_data,
    output matrix_t                matrix
);

    logic [data_code_w-1:0] code_q;
    logic                   valid_d;
    logic [3:0]             wr_ptr;
    entry_t                 entry;
    matrix_t                mat_q;

    hamming_decoder #(.payload_t(entry_t)) u_data_dec (
        .code (code_q),
        .data (entry)
    );

    always_ff @(posedge clk) begin
        if (in_valid) begin
            code_q <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            wr_ptr  <= '0;
        end else begin
            valid_d <= in_valid;
            wr_ptr  <= valid_d ? wr_ptr + 4'd1 : 4'd0;
        end
    end

    // Upper pointer bits pick the row
    always_ff @(posedge clk) begin
        if (valid_d) begin
            mat_q.e[wr_ptr[3:2]][wr_ptr[1:0]] <= entry;
        end
    end

    assign matrix = mat_q;

endmodule

//--- det/det2_unit.sv
/*
  One 2x2 window determinant per step, nine steps in all.
  Results stay valid until the next run in 2x2 mode.
*/
`timescale 1ns/10ps

module det2_unit import mdc_data_pkg::*, mdc_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ctrl_t                  ctrl,
    input  matrix_t                matrix,
    output det2_t [0:n_det2-1]     det2_res
);

    logic [1:0] r;
    logic [1:0] c;
    entry_t     a;
    entry_t     b;
    entry_t     g;
    entry_t     d;
    det2_t      det;

    // Window corner at row s/3, column s%3
    always_comb begin
        r = 2'(ctrl.step / 3);
        c = 2'(ctrl.step % 3);
        a = matrix.e[r][c];
        b = matrix.e[r][c + 2'd1];
        g = matrix.e[r + 2'd1][c];
        d = matrix.e[r + 2'd1][c + 2'd1];
        det = a * d - b * g;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            det2_res <= '0;
        end else if (ctrl.det2_en) begin
            det2_res[ctrl.step] <= det;
        end
    end

endmodule

//--- det/det3_unit.sv
/*
  Cofactor expansion along the first column, three steps for each of
  the four 3x3 submatrices. Term 0 overwrites the accumulator.
*/
`timescale 1ns/10ps

module det3_unit import mdc_data_pkg::*, mdc_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ctrl_t                  ctrl,
    input  matrix_t                matrix,
    output det3_t [0:n_det3-1]     det3_res
);

    logic [1:0] k;
    logic [1:0] t;
    logic [1:0] rb;
    logic [1:0] cb;
    logic [1:0] ra;
    logic [1:0] rc;
    entry_t     coef;
    det2_t      minor;
    det3_t      term;

    always_comb begin
        k  = 2'(ctrl.step / 3);
        t  = 2'(ctrl.step % 3);
        rb = {1'b0, k[1]};
        cb = {1'b0, k[0]};
        // The two rows left over once row t is taken out
        ra = rb + ((t == 2'd0) ? 2'd1 : 2'd0);
        rc = rb + ((t == 2'd2) ? 2'd1 : 2'd2);
        coef  = matrix.e[rb + t][cb];
        minor = matrix.e[ra][cb + 2'd1] * matrix.e[rc][cb + 2'd2]
              - matrix.e[ra][cb + 2'd2] * matrix.e[rc][cb + 2'd1];
        term  = coef * minor;
    end

    // ####################
    // Accumulators
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            det3_res <= '0;
        end else if (ctrl.det3_en) begin
            if (t == 2'd0) begin
                det3_res[k] <= term;
            end else if (t[0]) begin
                det3_res[k] <= det3_res[k] - term;
            end else begin
                det3_res[k] <= det3_res[k] + term;
            end
        end
    end

endmodule

//--- src/result_reg.sv
/*
  Output register. out_data holds its value between loads and
  out_valid is a single-cycle pulse after each load.
*/
`timescale 1ns/10ps

module result_reg import mdc_data_pkg::*, mdc_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ctrl_t                ctrl,
    input  det2_t [0:n_det2-1]   det2_res,
    input  det3_t [0:n_det3-1]   det3_res,
    output logic                 out_valid,
    output result_t              out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= ctrl.load;
            if (ctrl.load) begin
                // Slot 0 ends up most significant in both layouts
                out_data <= ctrl.sel_det3 ? {3'b000, det3_res} : det2_res;
            end
        end
    end

endmodule

//--- src/mdc_top.sv
/*
  Matrix determinant calculator top. No back-pressure: in_valid must be
  high for sixteen cycles and a new matrix waits for out_valid.
*/
`timescale 1ns/10ps

module mdc_top import mdc_data_pkg::*, mdc_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [data_code_w-1:0] in_data,
    input  logic [mode_code_w-1:0] in_mode,
    output logic                   out_valid,
    output result_t                out_data
);

    ctrl_t              ctrl;
    matrix_t            matrix;
    det2_t [0:n_det2-1] det2_res;
    det3_t [0:n_det3-1] det3_res;

    mdc_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_mode  (in_mode),
        .ctrl     (ctrl)
    );

    matrix_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .matrix   (matrix)
    );

    det2_unit u_det2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .matrix   (matrix),
        .det2_res (det2_res)
    );

    det3_unit u_det3 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .matrix   (matrix),
        .det3_res (det3_res)
    );

    result_reg u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .det2_res  (det2_res),
        .det3_res  (det3_res),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

//--- bench/mdc_checker.sv
/*
  Protocol assertions on the top level, bound into mdc_top.
  fail_count is read by the testbench at the end of the run.
*/
`timescale 1ns/10ps

module mdc_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid
);

    int fail_count = 0;

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high on two consecutive cycles");
            fail_count++;
        end

    a_no_rise_during_input: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> !in_valid)
        else begin
            $error("out_valid rose while in_valid was high");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high right after reset release");
            fail_count++;
        end

endmodule

bind mdc_top mdc_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

//--- bench/mdc_tb.sv
/*
  Directed tests for the determinant calculator. Inputs change on the
  rising edge, outputs are sampled on the falling edge.
*/
`timescale 1ns/10ps

module mdc_tb import mdc_data_pkg::*, mdc_ctrl_pkg::*; ();

    localparam int  max_matrices      = 12;
    localparam int  cycles_per_matrix = 40;
    localparam int  result_timeout    = 30;
    localparam real watchdog_ns       = (max_matrices * cycles_per_matrix + 20) * 100.0;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [data_code_w-1:0] in_data;
    logic [mode_code_w-1:0] in_mode;
    logic                   out_valid;
    result_t                out_data;

    integer seed;
    int     mat [0:15];
    int     pulse_count;

    mdc_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            pulse_count <= pulse_count + 1;
        end
    end

    // ####################
    // Models
    // ####################

    // Parity at positions 1, 2, 4, 8 counted from the MSB
    function automatic logic [14:0] encode(input logic [10:0] data, input int data_w);
        logic [14:0] code;
        int          code_w;
        int          k;
        logic        p;
        code_w = data_w + 4;
        code = '0;
        k = data_w - 1;
        for (int pos = 1; pos <= code_w; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                code[code_w-pos] = data[k];
                k--;
            end
        end
        for (int pb = 1; pb <= 8; pb = pb * 2) begin
            p = 1'b0;
            for (int pos = 1; pos <= code_w; pos++) begin
                if (pos != pb && (pos & pb) != 0) begin
                    p = p ^ code[code_w-pos];
                end
            end
            code[code_w-pb] = p;
        end
        return code;
    endfunction

    function automatic longint det2_at(input int r, input int c);
        return longint'(mat[r*4+c]) * mat[(r+1)*4+c+1]
             - longint'(mat[r*4+c+1]) * mat[(r+1)*4+c];
    endfunction

    // Expansion along the first row
    function automatic longint det3_at(input int r, input int c);
        longint a [0:2][0:2];
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                a[i][j] = mat[(r+i)*4+c+j];
            end
        end
        return a[0][0] * (a[1][1] * a[2][2] - a[1][2] * a[2][1])
             - a[0][1] * (a[1][0] * a[2][2] - a[1][2] * a[2][0])
             + a[0][2] * (a[1][0] * a[2][1] - a[1][1] * a[2][0]);
    endfunction

    function automatic result_t expected_result(input bit det3);
        result_t r;
        longint  d;
        r = '0;
        if (det3) begin
            for (int k = 0; k < 4; k++) begin
                d = det3_at(k / 2, k % 2);
                r = r << 51;
                r[50:0] = d[50:0];
            end
        end else begin
            for (int s = 0; s < 9; s++) begin
                d = det2_at(s / 3, s % 3);
                r = r << 23;
                r[22:0] = d[22:0];
            end
        end
        return r;
    endfunction

    // ####################
    // Drivers and checks
    // ####################
    task automatic check(input string name, input logic [206:0] got,
                         input logic [206:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic int random_index(input int n);
        int v;
        v = $random(seed);
        return (v & 32'h7fffffff) % n;
    endfunction

    task automatic fill_random();
        int     v;
        entry_t e;
        for (int i = 0; i < 16; i++) begin
            v = $random(seed);
            e = v[10:0];
            mat[i] = e;
        end
    endtask

    task automatic send_matrix(input bit det3, input bit flip);
        logic [14:0] code;
        logic [14:0] mcode;
        mode_t       mode;
        int          idx;
        mode = det3 ? mode_det3 : 5'b00001;
        mcode = encode(11'(mode), mode_w);
        if (flip) begin
            idx = random_index(mode_code_w);
            mcode[idx] = ~mcode[idx];
        end
        for (int i = 0; i < 16; i++) begin
            code = encode(11'(mat[i]), entry_w);
            if (flip) begin
                idx = random_index(data_code_w);
                code[idx] = ~code[idx];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= code;
            in_mode  <= (i == 0) ? mcode[8:0] : '0;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_data  <= '0;
    endtask

    task automatic wait_for_result();
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid && n < result_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("no out_valid within %0d cycles of the last entry", result_timeout);
            $display("Regression failed");
            $fatal(1, "result never arrived");
        end
    endtask

    task automatic run_matrix(input string test, input bit det3, input bit flip);
        result_t exp;
        exp = expected_result(det3);
        send_matrix(det3, flip);
        wait_for_result();
        if (det3) begin
            check($sformatf("out_data[206:204] (%s)", test), out_data[206:204], '0);
        end
        check($sformatf("out_data (%s)", test), out_data, exp);
    endtask

    // ####################
    // Tests
    // ####################
    task automatic det2_fixed();
        mat = '{3, -7, 12, 5, 0, 8, -2, 9, 14, -11, 6, 1, -5, 4, 10, -3};
        run_matrix("det2_fixed", 1'b0, 1'b0);
    endtask

    task automatic det3_fixed();
        mat = '{2, -1, 0, 4, 7, 3, -5, 1, -6, 8, 9, -2, 1, 0, -4, 11};
        run_matrix("det3_fixed", 1'b1, 1'b0);
    endtask

    task automatic hamming_correction();
        fill_random();
        run_matrix("hamming_correction 3x3", 1'b1, 1'b1);
        fill_random();
        run_matrix("hamming_correction 2x2", 1'b0, 1'b1);
    endtask

    task automatic extreme_values();
        int v;
        // Checkerboard first, then a random choice of the two extremes
        for (int i = 0; i < 16; i++) begin
            mat[i] = (((i >> 2) ^ i) & 1) ? 1023 : -1024;
        end
        run_matrix("extreme_values 2x2", 1'b0, 1'b0);
        run_matrix("extreme_values 3x3", 1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            v = $random(seed);
            mat[i] = v[0] ? 1023 : -1024;
        end
        run_matrix("extreme_values 2x2", 1'b0, 1'b0);
        run_matrix("extreme_values 3x3", 1'b1, 1'b0);
    endtask

    task automatic back_to_back();
        int start_count;
        // Let the previous pulse reach the counter first
        @(posedge clk);
        start_count = pulse_count;
        for (int n = 0; n < 4; n++) begin
            fill_random();
            run_matrix($sformatf("back_to_back %0d", n), n[0], 1'b0);
        end
        repeat (3) @(posedge clk);
        check("out_valid pulse count", pulse_count - start_count, 4);
    endtask

    initial begin
        seed        = 32'hd905aad6;
        pulse_count = 0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_mode     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        det2_fixed();
        det3_fixed();
        hamming_correction();
        extreme_values();
        back_to_back();
        repeat (2) @(posedge clk);
        if (u_dut.u_checker.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (u_dut.u_checker.fail_count != 0);
        $display("protocol assertion failed in the bound checker");
        $display("Regression failed");
        $fatal(1, "assertion failure");
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

//--- build.f
common/mdc_data_pkg.sv
common/mdc_ctrl_pkg.sv
src/hamming_decoder.sv
src/mdc_ctrl.sv
src/matrix_store.sv
det/det2_unit.sv
det/det3_unit.sv
src/result_reg.sv
src/mdc_top.sv
bench/mdc_checker.sv
bench/mdc_tb.sv

//--- Bender.yml
package:
  name: mdc

sources:
  - common/mdc_data_pkg.sv
  - common/mdc_ctrl_pkg.sv
  - src/hamming_decoder.sv
  - src/mdc_ctrl.sv
  - src/matrix_store.sv
  - det/det2_unit.sv
  - det/det3_unit.sv
  - src/result_reg.sv
  - src/mdc_top.sv
  - target: test
    files:
      - bench/mdc_checker.sv
      - bench/mdc_tb.sv
